// File: bench/tb_gx_checks.svh
`ifndef TB_GX_CHECKS_SVH
`define TB_GX_CHECKS_SVH

    // A miss marks the running step as failed
    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected 8'h%02h, actual 8'h%02h", name, expected, actual);
            step_failed = 1'b1;
            error_count++;
        end
    endtask

    task automatic check_addr(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected 16'h%04h, actual 16'h%04h", name, expected, actual);
            step_failed = 1'b1;
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %b, actual %b", name, expected, actual);
            step_failed = 1'b1;
            error_count++;
        end
    endtask

    task automatic check_regs(input string name, input page_regs_t expected,
                              input page_regs_t actual);
        string exp_text;
        string act_text;
        if (actual !== expected) begin
            exp_text = $sformatf("scroll %02h vector %02h line %02h",
                                 expected.scroll, expected.interrupt_vector,
                                 expected.pri_line);
            act_text = $sformatf("scroll %02h vector %02h line %02h",
                                 actual.scroll, actual.interrupt_vector, actual.pri_line);
            $display("ERR %s: expected %s, actual %s", name, exp_text, act_text);
            step_failed = 1'b1;
            error_count++;
        end
    endtask

    // One line per step
    task automatic close_step(input string name);
        if (step_failed) begin
            fail_count++;
        end else begin
            pass_count++;
            $display("ok  %s", name);
        end
    endtask

`endif

// File: bench/tb_gx_asic.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gx_asic
    import gx_asic_pkg::*;
();

    localparam int clk_half_ns     = 5;
    localparam int reset_cycles    = 4;
    localparam int step_cycles_max = 20;

    typedef enum logic [1:0] {
        op_write,
        op_read,
        op_raster,
        op_wait
    } step_op_t;

    // Read steps keep the expected sdram_oe in exp_bit, writes the sdram_we
    typedef struct packed {
        step_op_t    op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  exp_byte;
        logic        exp_bit;
        page_regs_t  exp_regs;
    } step_t;

    logic            clk_sys;
    logic            reset;
    logic            plus_mode;
    logic            use_asic;
    cpu_bus_t        cpu;
    logic [7:0]      raster_line;
    logic [3:0][5:0] analog_in;
    logic [2:0]      dma_status;
    logic [15:0]     sdram_addr;
    logic [7:0]      sdram_din;
    logic            sdram_we;
    logic            sdram_oe;
    logic [7:0]      sdram_dout = 8'h00;
    logic [7:0]      cpu_data_out;
    page_regs_t      page_regs;
    logic            pri_irq;

    step_t steps[$];
    string step_names[$];
    logic  table_ready = 1'b0;
    logic  step_failed = 1'b0;
    int    pass_count = 0;
    int    fail_count = 0;
    int    error_count = 0;

    `include "tb_gx_checks.svh"

    gx_asic dut0 (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .plus_mode    (plus_mode),
        .use_asic     (use_asic),
        .cpu          (cpu),
        .raster_line  (raster_line),
        .analog_in    (analog_in),
        .dma_status   (dma_status),
        .sdram_addr   (sdram_addr),
        .sdram_din    (sdram_din),
        .sdram_we     (sdram_we),
        .sdram_oe     (sdram_oe),
        .sdram_dout   (sdram_dout),
        .cpu_data_out (cpu_data_out),
        .page_regs    (page_regs),
        .pri_irq      (pri_irq)
    );

    function automatic logic [7:0] sdram_model_byte(input logic [15:0] addr);
        return addr[7:0] ^ 8'h5A;
    endfunction

    task automatic add_step(input string name, input step_op_t op, input logic [15:0] addr,
                            input logic [7:0] data, input logic [7:0] exp_byte,
                            input logic exp_bit, input page_regs_t exp_regs);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.exp_byte = exp_byte;
        s.exp_bit  = exp_bit;
        s.exp_regs = exp_regs;
        steps.push_back(s);
        step_names.push_back(name);
    endtask

    task automatic apply_step(input step_t s, input string name);
        step_failed = 1'b0;
        @(posedge clk_sys);
        #1;
        if (s.op == op_write || s.op == op_read) begin
            cpu.addr = s.addr;
            cpu.data = s.data;
            cpu.wr   = (s.op == op_write);
            cpu.rd   = (s.op == op_read);
        end else if (s.op == op_raster) begin
            raster_line = s.data;
        end
        // SDRAM levels follow the strobe within the cycle
        #4;
        if (s.op == op_write)
            check_bit({name, " sdram_we"}, s.exp_bit, sdram_we);
        if (s.op == op_read)
            check_bit({name, " sdram_oe"}, s.exp_bit, sdram_oe);
        // Address and write data pass straight through to SDRAM
        if (s.op == op_write || s.op == op_read)
            check_addr({name, " sdram_addr"}, s.addr, sdram_addr);
        if (s.op == op_write)
            check_byte({name, " sdram_din"}, s.data, sdram_din);
        @(posedge clk_sys);
        #1;
        cpu.wr = 1'b0;
        cpu.rd = 1'b0;
        #4;
        if (s.op == op_read)
            check_byte(name, s.exp_byte, cpu_data_out);
        else if (s.op == op_raster)
            check_bit(name, s.exp_bit, pri_irq);
        else if (s.op == op_wait)
            check_regs(name, s.exp_regs, page_regs);
        close_step(name);
    endtask

    initial begin
        clk_sys = 1'b0;
        forever #clk_half_ns clk_sys = ~clk_sys;
    end

    // Read data held from the read cycle
    always @(posedge clk_sys) begin
        if (sdram_oe)
            sdram_dout <= sdram_model_byte(sdram_addr);
    end

    initial begin
        page_regs_t regs_exp;
        logic [7:0] vec_byte;
        void'($urandom(32'h47b7));
        for (int k = 0; k < 4; k++)
            analog_in[2'(k)] = 6'($urandom());
        dma_status  = 3'($urandom());
        reset       = 1'b1;
        plus_mode   = 1'b1;
        use_asic    = 1'b1;
        cpu         = '0;
        raster_line = 8'h00;

        // Scroll byte 0xC5 split into its fields
        regs_exp.scroll.extend_border = 1'b1;
        regs_exp.scroll.soft_scroll_v = 3'b100;
        regs_exp.scroll.soft_scroll_h = 4'h5;
        // Vector keeps bits 7:3 of the written byte
        vec_byte = 8'hF8;
        regs_exp.interrupt_vector = vec_byte[7:3];
        regs_exp.pri_line = 8'h40;

        add_step("unmapped wr 6000", op_write, 16'h6000, 8'h11, 8'h00, 1'b1, '0);
        add_step("unmapped rd 6000", op_read, 16'h6000, 8'h00,
                 sdram_model_byte(16'h6000), 1'b1, '0);
        add_step("idle rd 1234", op_read, 16'h1234, 8'h00, 8'hFF, 1'b0, '0);
        add_step("mode 05", op_write, 16'hBC00, 8'h05, 8'h00, 1'b0, '0);
        add_step("rmr2 18", op_write, 16'hBC01, 8'h18, 8'h00, 1'b0, '0);
        add_step("locked rd 5000", op_read, 16'h5000, 8'h00,
                 sdram_model_byte(16'h5000), 1'b1, '0);
        add_step("unlock 62", op_write, 16'hBC00, 8'h62, 8'h00, 1'b0, '0);
        add_step("mapped wr 5000", op_write, 16'h5000, 8'h3C, 8'h00, 1'b1, '0);
        add_step("mapped rd 5000", op_read, 16'h5000, 8'h00, 8'h3C, 1'b0, '0);
        add_step("palette wr 6401", op_write, 16'h6401, 8'hA7, 8'h00, 1'b1, '0);
        add_step("palette rd 6401", op_read, 16'h6401, 8'h00, 8'hA7 & 8'h0F, 1'b0, '0);
        add_step("palette wr 6400", op_write, 16'h6400, 8'hA7, 8'h00, 1'b1, '0);
        add_step("palette rd 6400", op_read, 16'h6400, 8'h00, 8'hA7, 1'b0, '0);
        for (int k = 0; k < 4; k++)
            add_step($sformatf("analog rd %04h", analog_first + 16'(k)), op_read,
                     analog_first + 16'(k), 8'h00, {2'b00, analog_in[2'(k)]}, 1'b0, '0);
        add_step("fixed rd 680c", op_read, fixed_3f_a, 8'h00, 8'h3F, 1'b0, '0);
        add_step("fixed rd 680d", op_read, fixed_00_a, 8'h00, 8'h00, 1'b0, '0);
        add_step("fixed rd 680e", op_read, fixed_3f_b, 8'h00, 8'h3F, 1'b0, '0);
        add_step("fixed rd 680f", op_read, fixed_00_b, 8'h00, 8'h00, 1'b0, '0);
        add_step("dma rd 6c0f", op_read, dma_status_addr, 8'h00,
                 {dma_status, 5'b00000}, 1'b0, '0);
        add_step("pri line wr", op_write, pri_line_addr, 8'h40, 8'h00, 1'b1, '0);
        add_step("scroll wr", op_write, scroll_addr, 8'hC5, 8'h00, 1'b1, '0);
        add_step("vector wr", op_write, vector_addr, 8'hF8, 8'h00, 1'b1, '0);
        add_step("page regs", op_wait, 16'h0000, 8'h00, 8'h00, 1'b0, regs_exp);
        add_step("raster 3f", op_raster, 16'h0000, 8'h3F, 8'h00, 1'b0, '0);
        add_step("raster 40", op_raster, 16'h0000, 8'h40, 8'h00, 1'b1, '0);
        add_step("raster 41", op_raster, 16'h0000, 8'h41, 8'h00, 1'b0, '0);
        add_step("relock mode 05", op_write, 16'hBC00, 8'h05, 8'h00, 1'b0, '0);
        add_step("relocked rd 5000", op_read, 16'h5000, 8'h00,
                 sdram_model_byte(16'h5000), 1'b1, '0);
        // Disabled ASIC keeps the raster interrupt low on a matching line
        add_step("relocked raster 40", op_raster, 16'h0000, 8'h40, 8'h00, 1'b0, '0);
        table_ready = 1'b1;

        repeat (reset_cycles) @(posedge clk_sys);
        #1;
        reset = 1'b0;
        for (int i = 0; i < steps.size(); i++)
            apply_step(steps[i], step_names[i]);

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 steps.size(), pass_count, fail_count, error_count);
        if (fail_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        int limit_cycles;
        wait (table_ready);
        limit_cycles = steps.size() * step_cycles_max + reset_cycles;
        repeat (limit_cycles) @(posedge clk_sys);
        $display("Timeout: the test table did not finish within %0d cycles", limit_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: gx_asic.f
+incdir+bench
hdl/gx_asic_pkg.sv
hdl/gx_asic_ram.sv
hdl/gx_mode_regs.sv
hdl/gx_register_page.sv
hdl/gx_bus_router.sv
hdl/gx_asic.sv
bench/tb_gx_asic.sv

// File: hdl/gx_asic.sv
`timescale 1ns/1ps
`default_nettype none

module gx_asic
    import gx_asic_pkg::*;
(
    input  wire logic            clk_sys,
    input  wire logic            reset,
    input  wire logic            plus_mode,
    input  wire logic            use_asic,
    input  wire cpu_bus_t        cpu,
    input  wire logic [7:0]      raster_line,
    input  wire logic [3:0][5:0] analog_in,
    input  wire logic [2:0]      dma_status,
    output logic [15:0]          sdram_addr,
    output logic [7:0]           sdram_din,
    output logic                 sdram_we,
    output logic                 sdram_oe,
    input  wire logic [7:0]      sdram_dout,
    output logic [7:0]           cpu_data_out,
    output page_regs_t           page_regs,
    output logic                 pri_irq
);

    logic       page_mapped;
    logic       asic_active;
    logic       page_wr;
    logic       page_rd;
    logic [7:0] page_rdata;

    gx_mode_regs mode_regs0 (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .plus_mode   (plus_mode),
        .use_asic    (use_asic),
        .cpu         (cpu),
        .page_mapped (page_mapped),
        .asic_active (asic_active)
    );

    gx_register_page register_page0 (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .cpu         (cpu),
        .page_wr     (page_wr),
        .page_rd     (page_rd),
        .asic_active (asic_active),
        .raster_line (raster_line),
        .analog_in   (analog_in),
        .dma_status  (dma_status),
        .page_regs   (page_regs),
        .pri_irq     (pri_irq),
        .page_rdata  (page_rdata)
    );

    // Router owns the CPU side and the SDRAM levels
    gx_bus_router bus_router0 (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .cpu          (cpu),
        .page_mapped  (page_mapped),
        .page_wr      (page_wr),
        .page_rd      (page_rd),
        .sdram_addr   (sdram_addr),
        .sdram_din    (sdram_din),
        .sdram_we     (sdram_we),
        .sdram_oe     (sdram_oe),
        .sdram_dout   (sdram_dout),
        .page_rdata   (page_rdata),
        .cpu_data_out (cpu_data_out)
    );

endmodule

`default_nettype wire

// File: hdl/gx_asic_pkg.sv
`default_nettype none

package gx_asic_pkg;

    // CPU bus as seen by every block
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        wr;
        logic        rd;
    } cpu_bus_t;

    // Soft scroll byte at 0x6804
    typedef struct packed {
        logic       extend_border;
        logic [2:0] soft_scroll_v;
        logic [3:0] soft_scroll_h;
    } scroll_t;

    // Page registers exported from the register page
    typedef struct packed {
        scroll_t    scroll;
        logic [4:0] interrupt_vector;
        logic [7:0] pri_line;
    } page_regs_t;

    // Where the last CPU read was served from
    typedef enum logic [1:0] {
        src_none,
        src_page,
        src_sdram
    } read_src_t;

    // Mapped page window
    localparam logic [15:0] page_base       = 16'h4000;
    localparam logic [15:0] page_last       = 16'h7FFF;

    // Palette bytes, odd ones keep only the low nibble
    localparam logic [15:0] palette_first   = 16'h6400;
    localparam logic [15:0] palette_last    = 16'h643F;

    // Write-captured registers
    localparam logic [15:0] pri_line_addr   = 16'h6800;
    localparam logic [15:0] scroll_addr     = 16'h6804;
    localparam logic [15:0] vector_addr     = 16'h6805;

    // Read-only locations
    localparam logic [15:0] analog_first    = 16'h6808;
    localparam logic [15:0] analog_last     = 16'h680B;
    localparam logic [15:0] fixed_3f_a      = 16'h680C;
    localparam logic [15:0] fixed_00_a      = 16'h680D;
    localparam logic [15:0] fixed_3f_b      = 16'h680E;
    localparam logic [15:0] fixed_00_b      = 16'h680F;
    localparam logic [15:0] dma_status_addr = 16'h6C0F;

    // Mode port high byte, 0xBC00 and 0xBC01
    localparam logic [7:0]  mode_port_hi    = 8'hBC;

    // Mode bytes that enable the ASIC
    localparam logic [7:0]  unlock_a        = 8'h02;
    localparam logic [7:0]  unlock_b        = 8'h62;
    localparam logic [7:0]  unlock_c        = 8'h82;

    // 16 KB of ASIC RAM
    localparam int          asic_ram_aw     = 14;

    // Value of a read that hits nothing
    localparam logic [7:0]  idle_read       = 8'hFF;

endpackage

`default_nettype wire

// File: hdl/gx_asic_ram.sv
`timescale 1ns/1ps
`default_nettype none

module gx_asic_ram
    import gx_asic_pkg::*;
#(
    parameter int addr_w = asic_ram_aw,
    parameter int data_w = 8
) (
    input  wire logic              clk_sys,
    input  wire logic [addr_w-1:0] addr,
    input  wire logic              we,
    input  wire logic [data_w-1:0] wdata,
    output logic      [data_w-1:0] q
);

    localparam int depth = 1 << addr_w;

    logic [data_w-1:0] mem [depth];

    // Write-first, new data appears on q with the write
    always_ff @(posedge clk_sys) begin
        if (we) begin
            mem[addr] <= wdata;
            q         <= wdata;
        end else begin
            q <= mem[addr];
        end
    end

    a_write_addr_known: assert property (
        @(posedge clk_sys) we |-> !$isunknown(addr)
    );

endmodule

`default_nettype wire

// File: hdl/gx_bus_router.sv
`timescale 1ns/1ps
`default_nettype none

module gx_bus_router
    import gx_asic_pkg::*;
(
    input  wire logic       clk_sys,
    input  wire logic       reset,
    input  wire cpu_bus_t   cpu,
    input  wire logic       page_mapped,
    output logic            page_wr,
    output logic            page_rd,
    output logic [15:0]     sdram_addr,
    output logic [7:0]      sdram_din,
    output logic            sdram_we,
    output logic            sdram_oe,
    input  wire logic [7:0] sdram_dout,
    input  wire logic [7:0] page_rdata,
    output logic [7:0]      cpu_data_out
);

    logic      in_page;
    read_src_t read_src;

    // Single range test for the whole 16 KB window
    assign in_page = (cpu.addr >= page_base) && (cpu.addr <= page_last);

    // Mapped reads go to the page, unmapped ones to SDRAM
    assign page_rd  = cpu.rd && in_page && page_mapped;
    assign sdram_oe = cpu.rd && in_page && !page_mapped;

    // Writes always reach SDRAM
    assign page_wr  = cpu.wr && in_page && page_mapped;
    assign sdram_we = cpu.wr && in_page;

    assign sdram_addr = cpu.addr;
    assign sdram_din  = cpu.data;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            read_src <= src_none;
        end else if (cpu.rd) begin
            if (page_rd)
                read_src <= src_page;
            else if (sdram_oe)
                read_src <= src_sdram;
            else
                read_src <= src_none;
        end
    end

    // SDRAM data passes live, the outside holds it after the read
    always_comb begin
        case (read_src)
            src_page:  cpu_data_out = page_rdata;
            src_sdram: cpu_data_out = sdram_dout;
            default:   cpu_data_out = idle_read;
        endcase
    end

    a_cpu_strobes_exclusive: assert property (
        @(posedge clk_sys) disable iff (reset)
        !(cpu.wr && cpu.rd)
    );

endmodule

`default_nettype wire

// File: hdl/gx_mode_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gx_mode_regs
    import gx_asic_pkg::*;
(
    input  wire logic     clk_sys,
    input  wire logic     reset,
    input  wire logic     plus_mode,
    input  wire logic     use_asic,
    input  wire cpu_bus_t cpu,
    output logic          page_mapped,
    output logic          asic_active
);

    logic [7:0] asic_mode;
    logic [7:0] rmr2;
    logic       asic_enabled;
    logic       mode_port_wr;

    function automatic logic is_unlock(input logic [7:0] value);
        return (value == unlock_a) || (value == unlock_b) || (value == unlock_c);
    endfunction

    assign mode_port_wr = cpu.wr && (cpu.addr[15:8] == mode_port_hi);

    // Address bit picks the register, 0xBC00 mode and 0xBC01 RMR2
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            asic_mode    <= 8'h00;
            rmr2         <= 8'h00;
            asic_enabled <= 1'b0;
        end else if (mode_port_wr) begin
            if (cpu.addr[7:0] == 8'h00) begin
                asic_mode    <= cpu.data;
                asic_enabled <= is_unlock(cpu.data);
            end else if (cpu.addr[7:0] == 8'h01) begin
                rmr2 <= cpu.data;
            end
        end
    end

    assign asic_active = asic_enabled && plus_mode && use_asic;

    // Page shows up only with RMR2 bits 4 and 3 both set
    assign page_mapped = asic_active && rmr2[4] && rmr2[3];

    // Enable never survives a mode write that was not an unlock code
    a_enable_from_unlock: assert property (
        @(posedge clk_sys) disable iff (reset)
        asic_enabled |-> is_unlock(asic_mode)
    );

endmodule

`default_nettype wire

// File: hdl/gx_register_page.sv
`timescale 1ns/1ps
`default_nettype none

module gx_register_page
    import gx_asic_pkg::*;
(
    input  wire logic            clk_sys,
    input  wire logic            reset,
    input  wire cpu_bus_t        cpu,
    input  wire logic            page_wr,
    input  wire logic            page_rd,
    input  wire logic            asic_active,
    input  wire logic [7:0]      raster_line,
    input  wire logic [3:0][5:0] analog_in,
    input  wire logic [2:0]      dma_status,
    output page_regs_t           page_regs,
    output logic                 pri_irq,
    output logic [7:0]           page_rdata
);

    typedef enum logic [2:0] {
        sel_ram,
        sel_analog,
        sel_3f,
        sel_00,
        sel_dma
    } rd_sel_t;

    logic [15:0]            page_offset;
    logic [asic_ram_aw-1:0] ram_addr;
    logic                   ram_we;
    logic [7:0]             ram_wdata;
    logic [7:0]             ram_q;
    logic                   palette_odd;
    page_regs_t             regs_q;
    rd_sel_t                rd_sel_next;
    rd_sel_t                rd_sel;
    logic [1:0]             rd_chan;
    logic                   rd_pending;
    logic [7:0]             rdata_mux;
    logic [7:0]             rdata_hold;

    // RAM offset is CPU address minus page base
    assign page_offset = cpu.addr - page_base;
    assign ram_addr    = page_offset[asic_ram_aw-1:0];

    assign palette_odd = (cpu.addr >= palette_first) && (cpu.addr <= palette_last)
                         && cpu.addr[0];
    assign ram_we      = page_wr;
    assign ram_wdata   = palette_odd ? {4'h0, cpu.data[3:0]} : cpu.data;

    gx_asic_ram #(
        .addr_w (asic_ram_aw),
        .data_w (8)
    ) ram0 (
        .clk_sys (clk_sys),
        .addr    (ram_addr),
        .we      (ram_we),
        .wdata   (ram_wdata),
        .q       (ram_q)
    );

    // Registers also live in RAM, the copies here feed the video side
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            regs_q <= '0;
        end else if (page_wr) begin
            if (cpu.addr == pri_line_addr)
                regs_q.pri_line <= cpu.data;
            if (cpu.addr == scroll_addr)
                regs_q.scroll <= scroll_t'(cpu.data);
            if (cpu.addr == vector_addr)
                regs_q.interrupt_vector <= cpu.data[7:3];
        end
    end

    assign page_regs = regs_q;

    always_comb begin
        if ((cpu.addr >= analog_first) && (cpu.addr <= analog_last))
            rd_sel_next = sel_analog;
        else if ((cpu.addr == fixed_3f_a) || (cpu.addr == fixed_3f_b))
            rd_sel_next = sel_3f;
        else if ((cpu.addr == fixed_00_a) || (cpu.addr == fixed_00_b))
            rd_sel_next = sel_00;
        else if (cpu.addr == dma_status_addr)
            rd_sel_next = sel_dma;
        else
            rd_sel_next = sel_ram;
    end

    // Select is registered so it meets ram_q one cycle later
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rd_sel     <= sel_ram;
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= page_rd;
            if (page_rd)
                rd_sel <= rd_sel_next;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (page_rd)
            rd_chan <= cpu.addr[1:0];
        if (rd_pending)
            rdata_hold <= rdata_mux;
    end

    always_comb begin
        case (rd_sel)
            sel_analog: rdata_mux = {2'b00, analog_in[rd_chan]};
            sel_3f:     rdata_mux = 8'h3F;
            sel_00:     rdata_mux = 8'h00;
            sel_dma:    rdata_mux = {dma_status, 5'b00000};
            default:    rdata_mux = ram_q;
        endcase
    end

    // Hold the byte after the read cycle, RAM output moves with the address
    assign page_rdata = rd_pending ? rdata_mux : rdata_hold;

    // Programmable raster interrupt
    always_ff @(posedge clk_sys) begin
        if (reset)
            pri_irq <= 1'b0;
        else
            pri_irq <= asic_active && (raster_line == regs_q.pri_line);
    end

    a_page_strobes_exclusive: assert property (
        @(posedge clk_sys) disable iff (reset)
        !(page_wr && page_rd)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the gx_asic testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_gx_asic \
    -f gx_asic.f \
    -o tb_gx_asic

./obj_dir/tb_gx_asic > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
